/* common/heapGeometryPkg.sv */
/*
  Heap geometry
  Sizes of the array heap and the word types built from them
*/
`default_nettype none

package heapGeometryPkg;

  // ----------------------------
  // Sizes
  // ----------------------------
  localparam int ArrayBits = 2;                  // Bits in an array number
  localparam int IndexBits = 2;                  // Bits in an element index
  localparam int DataBits = 12;                  // Width of one element

  localparam int ArrayCount = 2 ** ArrayBits;    // Arrays in the heap
  localparam int ArrayLength = 2 ** IndexBits;   // Elements per array

  // ----------------------------
  // Word types
  // ----------------------------
  typedef logic [ArrayBits-1:0] arrayNumT;       // Array number

  typedef logic [IndexBits-1:0] indexT;          // Element index

  // One extra bit so a full array can report ArrayLength
  typedef logic [IndexBits:0] sizeT;

  typedef logic [DataBits-1:0] dataT;            // Data element

endpackage

`default_nettype wire

/* common/heapCommandPkg.sv */
/*
  Heap command encodings
  Opcodes, error codes, allocation states and the structs that
  carry commands, element access grants and responses
*/
`default_nettype none

package heapCommandPkg;

  // ----------------------------
  // Encodings
  // ----------------------------
  typedef enum logic [4:0] {
    opClear,                                     // Return every array to never used
    opAlloc,                                     // Hand out an array number
    opFree,                                      // Take an array back
    opWrite,                                     // Store at index, may grow size
    opRead,                                      // Fetch element at index
    opSize,                                      // Report array size
    opPush,                                      // Append one element
    opPop,                                       // Remove last element
    opResize,                                    // Set size directly
    opAdd,                                       // Add, return new value
    opAddAfter,                                  // Add, return old value
    opSub,                                       // Subtract, return new value
    opSubAfter,                                  // Subtract, return old value
    opOr,
    opXor,
    opAnd
  } heapOpT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                             // Array never handed out
    errFreed,                                    // Array handed out then freed
    errOutOfBounds,                              // Index at or past size
    errFull,                                     // Push onto a full array
    errEmpty,                                    // Pop from an empty array
    errOutOfMemory,                              // No array left to hand out
    errTooLarge                                  // Resize past the array length
  } heapErrorT;

  typedef enum logic [1:0] {
    stateNever,
    stateAllocated,
    stateFreed
  } arrayStateT;

  // ----------------------------
  // Structs
  // ----------------------------
  typedef struct packed {
    heapOpT op;
    heapGeometryPkg::arrayNumT array;
    heapGeometryPkg::indexT index;
    heapGeometryPkg::dataT in;
  } heapCommandT;

  // Size table verdict handed on to the element store
  typedef struct packed {
    logic grant;                                 // Element may be touched
    heapGeometryPkg::indexT slot;                // Element to touch
    heapGeometryPkg::sizeT oldSize;              // Size before this command
    heapErrorT error;                            // Final error
    heapGeometryPkg::arrayNumT allocNum;         // Array an alloc returns
  } heapAccessT;

  typedef struct packed {
    heapGeometryPkg::dataT out;
    heapErrorT error;
  } heapResponseT;

endpackage

`default_nettype wire

/* arrayHeap/arrayAllocator.sv */
/*
  Array allocator
  Hands out array numbers, takes freed ones back on a LIFO stack,
  and reports the allocation state of the commanded array
*/
`timescale 1ns/1ps
`default_nettype none

module arrayAllocator (
  input wire clock,
  input wire resetN,
  input wire cmdValid,
  input wire heapCommandPkg::heapCommandT cmd,
  input wire heapCommandPkg::heapErrorT sizeError,
  output heapCommandPkg::arrayStateT arrayState,
  output heapGeometryPkg::arrayNumT allocNum,
  output logic allocOk
);

  typedef logic [heapGeometryPkg::ArrayBits:0] countT;   // Zero up to ArrayCount

  countT handedOut;                                      // Arrays ever handed out
  countT freeTop;                                        // Entries on the free stack
  heapGeometryPkg::arrayNumT freeStack [heapGeometryPkg::ArrayCount];
  logic [heapGeometryPkg::ArrayCount-1:0] allocated;     // Currently in use
  heapGeometryPkg::arrayNumT topSlot;                    // Newest free stack entry
  logic commit;

  // ----------------------------
  // Lookups
  // ----------------------------
  assign topSlot = freeTop[heapGeometryPkg::ArrayBits-1:0] - 1'b1;

  always_comb begin
    if (allocated[cmd.array]) begin
      arrayState = heapCommandPkg::stateAllocated;
    end else if (countT'(cmd.array) < handedOut) begin
      arrayState = heapCommandPkg::stateFreed;           // Handed out earlier, not in use
    end else begin
      arrayState = heapCommandPkg::stateNever;
    end
  end

  // Most recently freed array wins, else the next fresh one
  always_comb begin
    if (freeTop != '0) begin
      allocNum = freeStack[topSlot];
    end else begin
      allocNum = handedOut[heapGeometryPkg::ArrayBits-1:0];
    end
  end

  assign allocOk = (freeTop != '0) || (handedOut != countT'(heapGeometryPkg::ArrayCount));

  assign commit = cmdValid && (sizeError == heapCommandPkg::errNone);

  // ----------------------------
  // Bookkeeping
  // ----------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      handedOut <= '0;
      freeTop <= '0;
      allocated <= '0;
    end else if (commit) begin
      case (cmd.op)
        heapCommandPkg::opClear: begin
          handedOut <= '0;
          freeTop <= '0;
          allocated <= '0;
        end
        heapCommandPkg::opAlloc: begin
          allocated[allocNum] <= 1'b1;
          if (freeTop != '0) begin
            freeTop <= freeTop - 1'b1;                   // Reuse a freed array
          end else begin
            handedOut <= handedOut + 1'b1;
          end
        end
        heapCommandPkg::opFree: begin
          allocated[cmd.array] <= 1'b0;
          freeTop <= freeTop + 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // Push the freed array onto the stack
  always_ff @(posedge clock) begin
    if (commit && cmd.op == heapCommandPkg::opFree) begin
      freeStack[freeTop[heapGeometryPkg::ArrayBits-1:0]] <= cmd.array;
    end
  end

endmodule

`default_nettype wire

/* arrayHeap/arraySizeTable.sv */
/*
  Array size table
  Holds each array's size, resolves the final error of a command
  and grants the element store access to one slot
*/
`timescale 1ns/1ps
`default_nettype none

module arraySizeTable (
  input wire clock,
  input wire resetN,
  input wire cmdValid,
  input wire heapCommandPkg::heapCommandT cmd,
  input wire heapCommandPkg::arrayStateT arrayState,
  input wire heapGeometryPkg::arrayNumT allocNum,
  input wire allocOk,
  output heapCommandPkg::heapAccessT access
);

  heapGeometryPkg::sizeT sizes [heapGeometryPkg::ArrayCount];
  heapGeometryPkg::sizeT curSize;                        // Size of commanded array
  heapGeometryPkg::sizeT indexSize;                      // Index widened to a size
  heapCommandPkg::heapErrorT error;
  logic touchesElem;                                     // Op reads or writes an element

  assign curSize = sizes[cmd.array];
  assign indexSize = {1'b0, cmd.index};

  // ----------------------------
  // Error resolution
  // ----------------------------
  always_comb begin
    error = heapCommandPkg::errNone;
    touchesElem = 1'b0;
    case (cmd.op)
      heapCommandPkg::opClear: begin
      end
      heapCommandPkg::opAlloc: begin
        if (!allocOk) error = heapCommandPkg::errOutOfMemory;
      end
      default: begin
        if (arrayState == heapCommandPkg::stateNever) begin
          error = heapCommandPkg::errNotAllocated;
        end else if (arrayState == heapCommandPkg::stateFreed) begin
          error = heapCommandPkg::errFreed;
        end else begin
          case (cmd.op)
            heapCommandPkg::opWrite: touchesElem = 1'b1;
            heapCommandPkg::opPush: begin
              touchesElem = 1'b1;
              if (curSize == heapGeometryPkg::sizeT'(heapGeometryPkg::ArrayLength)) begin
                error = heapCommandPkg::errFull;
              end
            end
            heapCommandPkg::opPop: begin
              touchesElem = 1'b1;
              if (curSize == '0) error = heapCommandPkg::errEmpty;
            end
            heapCommandPkg::opResize: begin
              if (cmd.in > heapGeometryPkg::dataT'(heapGeometryPkg::ArrayLength)) begin
                error = heapCommandPkg::errTooLarge;
              end
            end
            heapCommandPkg::opFree, heapCommandPkg::opSize: begin
            end
            default: begin                               // Read, arithmetic and bitwise ops
              touchesElem = 1'b1;
              if (indexSize >= curSize) error = heapCommandPkg::errOutOfBounds;
            end
          endcase
        end
      end
    endcase
  end

  // ----------------------------
  // Access to the element store
  // ----------------------------
  always_comb begin
    access.grant = touchesElem && (error == heapCommandPkg::errNone);
    access.oldSize = curSize;
    access.error = error;
    access.allocNum = allocNum;
    case (cmd.op)
      heapCommandPkg::opPush: access.slot = curSize[heapGeometryPkg::IndexBits-1:0];
      heapCommandPkg::opPop: access.slot = curSize[heapGeometryPkg::IndexBits-1:0] - 1'b1;
      default: access.slot = cmd.index;
    endcase
  end

  // ----------------------------
  // Size updates
  // ----------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapGeometryPkg::ArrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (cmdValid && error == heapCommandPkg::errNone) begin
      case (cmd.op)
        heapCommandPkg::opAlloc: sizes[allocNum] <= '0;  // Fresh array starts empty
        heapCommandPkg::opWrite: begin
          if (indexSize >= curSize) sizes[cmd.array] <= indexSize + 1'b1;
        end
        heapCommandPkg::opPush: sizes[cmd.array] <= curSize + 1'b1;
        heapCommandPkg::opPop: sizes[cmd.array] <= curSize - 1'b1;
        heapCommandPkg::opResize: sizes[cmd.array] <= heapGeometryPkg::sizeT'(cmd.in);
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* arrayHeap/elementStore.sv */
/*
  Element store
  Element memory with read-modify-write arithmetic and the
  registered response for every command
*/
`timescale 1ns/1ps
`default_nettype none

module elementStore (
  input wire clock,
  input wire resetN,
  input wire cmdValid,
  input wire heapCommandPkg::heapCommandT cmd,
  input wire heapCommandPkg::heapAccessT access,
  output logic rspValid,
  output heapCommandPkg::heapResponseT rsp
);

  heapGeometryPkg::dataT mem [heapGeometryPkg::ArrayCount][heapGeometryPkg::ArrayLength];
  heapGeometryPkg::dataT elem;                           // Element at the granted slot
  heapGeometryPkg::dataT newValue;                       // Value written back
  heapGeometryPkg::dataT outValue;                       // Response value
  logic storeElem;                                       // Op writes the slot

  assign elem = mem[cmd.array][access.slot];

  // ----------------------------
  // Element arithmetic
  // ----------------------------
  always_comb begin
    newValue = cmd.in;                                   // Write and push store in
    storeElem = 1'b0;
    case (cmd.op)
      heapCommandPkg::opWrite, heapCommandPkg::opPush: storeElem = 1'b1;
      heapCommandPkg::opAdd, heapCommandPkg::opAddAfter: begin
        newValue = elem + cmd.in;                        // Wraps at DataBits
        storeElem = 1'b1;
      end
      heapCommandPkg::opSub, heapCommandPkg::opSubAfter: begin
        newValue = elem - cmd.in;
        storeElem = 1'b1;
      end
      heapCommandPkg::opOr: begin
        newValue = elem | cmd.in;
        storeElem = 1'b1;
      end
      heapCommandPkg::opXor: begin
        newValue = elem ^ cmd.in;
        storeElem = 1'b1;
      end
      heapCommandPkg::opAnd: begin
        newValue = elem & cmd.in;
        storeElem = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (cmdValid && access.grant && storeElem) begin
      mem[cmd.array][access.slot] <= newValue;
    end
  end

  // ----------------------------
  // Response
  // ----------------------------
  always_comb begin
    outValue = '0;                                       // Clear, free, push, resize
    if (access.error == heapCommandPkg::errNone) begin
      case (cmd.op)
        heapCommandPkg::opAlloc: outValue = heapGeometryPkg::dataT'(access.allocNum);
        heapCommandPkg::opWrite: outValue = cmd.in;
        heapCommandPkg::opSize: outValue = heapGeometryPkg::dataT'(access.oldSize);
        heapCommandPkg::opRead, heapCommandPkg::opPop: outValue = elem;
        heapCommandPkg::opAddAfter, heapCommandPkg::opSubAfter: outValue = elem;
        heapCommandPkg::opAdd, heapCommandPkg::opSub: outValue = newValue;
        heapCommandPkg::opOr, heapCommandPkg::opXor: outValue = newValue;
        heapCommandPkg::opAnd: outValue = newValue;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= cmdValid;                              // One response per command
    end
  end

  // Response payload for the command taken at this edge
  always_ff @(posedge clock) begin
    if (cmdValid) begin
      rsp.out <= outValue;
      rsp.error <= access.error;
    end
  end

endmodule

`default_nettype wire

/* arrayHeap/arrayHeap.sv */
/*
  Array heap
  Fixed length arrays of data words behind one command port,
  with one registered response per command
*/
`timescale 1ns/1ps
`default_nettype none

module arrayHeap (
  input wire clock,
  input wire resetN,
  input wire cmdValid,
  input wire heapCommandPkg::heapCommandT cmd,
  output logic rspValid,
  output heapCommandPkg::heapResponseT rsp
);

  // ----------------------------
  // Chain between the stages
  // ----------------------------
  heapCommandPkg::arrayStateT arrayState;        // State of commanded array
  heapGeometryPkg::arrayNumT allocNum;           // Array an alloc would get
  logic allocOk;                                 // An array is available
  heapCommandPkg::heapAccessT access;            // Size table verdict

  // Allocation state, free stack and handed out count
  arrayAllocator allocator (
    .clock      (clock),
    .resetN     (resetN),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .sizeError  (access.error),                  // Final error gates commit
    .arrayState (arrayState),
    .allocNum   (allocNum),
    .allocOk    (allocOk)
  );

  // Sizes, error resolution and element grant
  arraySizeTable sizeTable (
    .clock      (clock),
    .resetN     (resetN),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .arrayState (arrayState),
    .allocNum   (allocNum),
    .allocOk    (allocOk),
    .access     (access)
  );

  // Element memory and response register
  elementStore store (
    .clock    (clock),
    .resetN   (resetN),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .access   (access),
    .rspValid (rspValid),
    .rsp      (rsp)
  );

endmodule

`default_nettype wire

/* sim/tbClockGen.sv */
/*
  Testbench clock and reset
  Free running clock and an active low reset held for a few cycles
*/
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
  parameter time Period = 100ns,
  parameter int ResetCycles = 3
) (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #(Period / 2) clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;                                   // Release away from the active edge
  end

endmodule

`default_nettype wire

/* sim/arrayHeapTb.sv */
/*
  Array heap testbench
  Directed and random commands checked against a reference model
*/
`timescale 1ns/1ps
`default_nettype none

module arrayHeapTb;

  localparam int DirectedCmds = 83;
  localparam int RandomCmds = 300;
  localparam int CycleLimit = 2 * (DirectedCmds + RandomCmds) + 50;

  logic clock;
  logic resetN;
  logic cmdValid;
  heapCommandPkg::heapCommandT cmd;
  logic rspValid;
  heapCommandPkg::heapResponseT rsp;

  heapCommandPkg::heapResponseT expectedQ [$];       // Responses still in flight
  int dataErrors = 0;
  int codeErrors = 0;
  int protocolErrors = 0;
  int cycles = 0;
  logic [31:0] rngState = 32'hc8c9;

  // Reference model state
  int modelHandedOut;
  heapGeometryPkg::arrayNumT modelFreeStack [$];
  logic modelInUse [heapGeometryPkg::ArrayCount];
  int modelSize [heapGeometryPkg::ArrayCount];
  heapGeometryPkg::dataT modelMem [heapGeometryPkg::ArrayCount][heapGeometryPkg::ArrayLength];

  tbClockGen clockGen (.clock(clock), .resetN(resetN));

  arrayHeap i_dut (
    .clock    (clock),
    .resetN   (resetN),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .rspValid (rspValid),
    .rsp      (rsp)
  );

  function automatic logic [31:0] nextRandom();
    logic [31:0] s;
    s = rngState;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rngState = s;
    return s;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic heapCommandPkg::heapResponseT heapModel(
    input heapCommandPkg::heapCommandT c
  );
    heapCommandPkg::heapResponseT r;
    int sz;
    int idx;
    heapGeometryPkg::dataT old;
    heapGeometryPkg::dataT upd;
    r.out = '0;
    r.error = heapCommandPkg::errNone;
    sz = modelSize[c.array];
    idx = int'(c.index);
    old = modelMem[c.array][c.index];
    if (c.op == heapCommandPkg::opClear) begin
      modelHandedOut = 0;
      modelFreeStack.delete();
      for (int i = 0; i < heapGeometryPkg::ArrayCount; i++) modelInUse[i] = 1'b0;
      return r;
    end
    if (c.op == heapCommandPkg::opAlloc) begin
      if (modelFreeStack.size() != 0) begin
        r.out = heapGeometryPkg::dataT'(modelFreeStack.pop_back());   // LIFO reuse
      end else if (modelHandedOut < heapGeometryPkg::ArrayCount) begin
        r.out = heapGeometryPkg::dataT'(modelHandedOut);
        modelHandedOut++;
      end else begin
        r.error = heapCommandPkg::errOutOfMemory;
        return r;
      end
      modelInUse[r.out] = 1'b1;
      modelSize[r.out] = 0;
      return r;
    end
    if (!modelInUse[c.array]) begin
      if (int'(c.array) < modelHandedOut) r.error = heapCommandPkg::errFreed;
      else r.error = heapCommandPkg::errNotAllocated;
      return r;
    end
    case (c.op)
      heapCommandPkg::opWrite: begin
        modelMem[c.array][c.index] = c.in;
        if (idx >= sz) modelSize[c.array] = idx + 1;  // Write past the end grows
        r.out = c.in;
      end
      heapCommandPkg::opRead: begin
        if (idx >= sz) r.error = heapCommandPkg::errOutOfBounds;
        else r.out = old;
      end
      heapCommandPkg::opSize: r.out = heapGeometryPkg::dataT'(sz);
      heapCommandPkg::opPush: begin
        if (sz == heapGeometryPkg::ArrayLength) begin
          r.error = heapCommandPkg::errFull;
        end else begin
          modelMem[c.array][sz] = c.in;
          modelSize[c.array] = sz + 1;
        end
      end
      heapCommandPkg::opPop: begin
        if (sz == 0) begin
          r.error = heapCommandPkg::errEmpty;
        end else begin
          modelSize[c.array] = sz - 1;
          r.out = modelMem[c.array][sz - 1];        // Element just removed
        end
      end
      heapCommandPkg::opResize: begin
        if (int'(c.in) > heapGeometryPkg::ArrayLength) r.error = heapCommandPkg::errTooLarge;
        else modelSize[c.array] = int'(c.in);
      end
      heapCommandPkg::opFree: begin
        modelInUse[c.array] = 1'b0;
        modelFreeStack.push_back(c.array);
      end
      default: begin                                 // Arithmetic and bitwise ops
        if (idx >= sz) begin
          r.error = heapCommandPkg::errOutOfBounds;
        end else begin
          case (c.op)
            heapCommandPkg::opAdd, heapCommandPkg::opAddAfter: upd = old + c.in;
            heapCommandPkg::opSub, heapCommandPkg::opSubAfter: upd = old - c.in;
            heapCommandPkg::opOr: upd = old | c.in;
            heapCommandPkg::opXor: upd = old ^ c.in;
            default: upd = old & c.in;
          endcase
          modelMem[c.array][c.index] = upd;
          if (c.op == heapCommandPkg::opAddAfter || c.op == heapCommandPkg::opSubAfter) begin
            r.out = old;
          end else begin
            r.out = upd;
          end
        end
      end
    endcase
    return r;
  endfunction

  // ------------------------------
  // Stimulus and checks
  // ------------------------------
  task automatic issueCommand(input heapCommandPkg::heapOpT op,
                              input heapGeometryPkg::arrayNumT arr,
                              input heapGeometryPkg::indexT idx,
                              input heapGeometryPkg::dataT value);
    heapCommandPkg::heapCommandT c;
    c.op = op;
    c.array = arr;
    c.index = idx;
    c.in = value;
    @(negedge clock);
    cmd = c;
    cmdValid = 1'b1;
    expectedQ.push_back(heapModel(c));
  endtask

  task automatic checkData(input heapGeometryPkg::dataT expected,
                           input heapGeometryPkg::dataT actual);
    if (actual !== expected) begin
      dataErrors++;
      $display("Fail rsp.out expected %h actual %h", expected, actual);
    end
  endtask

  task automatic checkError(input heapCommandPkg::heapErrorT expected,
                            input heapCommandPkg::heapErrorT actual);
    if (actual !== expected) begin
      codeErrors++;
      $display("Fail rsp.error expected %h actual %h", expected, actual);
    end
  endtask

  // Compare process
  always @(posedge clock) begin
    heapCommandPkg::heapResponseT exp;
    if (rspValid === 1'b1) begin
      if (expectedQ.size() == 0) begin
        protocolErrors++;
        $display("Response arrived while no command was outstanding");
      end else begin
        exp = expectedQ.pop_front();
        checkData(exp.out, rsp.out);
        checkError(exp.error, rsp.error);
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles with %0d responses missing", cycles, expectedQ.size());
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    heapCommandPkg::heapOpT op;
    cmdValid = 1'b0;
    cmd = '0;
    modelHandedOut = 0;
    for (int a = 0; a < heapGeometryPkg::ArrayCount; a++) begin
      modelInUse[a] = 1'b0;
      modelSize[a] = 0;
    end
    @(posedge resetN);
    @(negedge clock);
    if (rspValid !== 1'b0) begin
      protocolErrors++;
      $display("rspValid is not low after reset");
    end

    // Alloc every array, fill all elements, then run out of memory
    issueCommand(heapCommandPkg::opClear, 0, 0, 0);
    repeat (4) issueCommand(heapCommandPkg::opAlloc, 0, 0, 0);
    for (int a = 0; a < heapGeometryPkg::ArrayCount; a++) begin
      for (int i = 0; i < heapGeometryPkg::ArrayLength; i++) begin
        issueCommand(heapCommandPkg::opWrite, a, i, 12'h5a0 + 12'(a * 37) + 12'(i * 11));
      end
    end
    issueCommand(heapCommandPkg::opAlloc, 0, 0, 0);

    // Push and read back
    issueCommand(heapCommandPkg::opClear, 0, 0, 0);
    issueCommand(heapCommandPkg::opAlloc, 0, 0, 0);
    issueCommand(heapCommandPkg::opPush, 0, 0, 1);
    issueCommand(heapCommandPkg::opPush, 0, 0, 2);
    issueCommand(heapCommandPkg::opSize, 0, 0, 0);
    issueCommand(heapCommandPkg::opRead, 0, 0, 0);
    issueCommand(heapCommandPkg::opRead, 0, 1, 0);

    // Free and reuse, double free, never allocated
    issueCommand(heapCommandPkg::opAlloc, 0, 0, 0);
    issueCommand(heapCommandPkg::opAlloc, 0, 0, 0);
    issueCommand(heapCommandPkg::opWrite, 1, 2, 12'h7c3);
    issueCommand(heapCommandPkg::opFree, 1, 0, 0);
    issueCommand(heapCommandPkg::opAlloc, 0, 0, 0);
    issueCommand(heapCommandPkg::opSize, 1, 0, 0);
    issueCommand(heapCommandPkg::opFree, 1, 0, 0);
    issueCommand(heapCommandPkg::opFree, 1, 0, 0);
    issueCommand(heapCommandPkg::opSize, 3, 0, 0);

    // Full, empty, bounds and size limit
    issueCommand(heapCommandPkg::opPush, 0, 0, 3);
    issueCommand(heapCommandPkg::opPush, 0, 0, 4);
    issueCommand(heapCommandPkg::opPush, 0, 0, 5);
    repeat (5) issueCommand(heapCommandPkg::opPop, 0, 0, 0);
    issueCommand(heapCommandPkg::opRead, 0, 0, 0);
    issueCommand(heapCommandPkg::opResize, 0, 0, 5);
    issueCommand(heapCommandPkg::opResize, 0, 0, 4);
    issueCommand(heapCommandPkg::opRead, 0, 3, 0);

    // Element arithmetic with wrap-around
    issueCommand(heapCommandPkg::opWrite, 0, 0, 12'hfff);
    issueCommand(heapCommandPkg::opAdd, 0, 0, 12'h002);
    issueCommand(heapCommandPkg::opWrite, 0, 1, 12'h000);
    issueCommand(heapCommandPkg::opSubAfter, 0, 1, 12'h001);
    issueCommand(heapCommandPkg::opRead, 0, 1, 0);
    for (int k = 0; k < 28; k++) begin
      r = nextRandom();
      op = heapCommandPkg::heapOpT'(int'(heapCommandPkg::opAdd) + (k % 7));
      issueCommand(op, 0, r[1:0], r[27:16]);
    end

    // Back to back random commands
    for (int k = 0; k < RandomCmds; k++) begin
      r = nextRandom();
      op = heapCommandPkg::heapOpT'(r[3:0]);
      if (op == heapCommandPkg::opClear && r[31:26] != 0) op = heapCommandPkg::opAlloc;
      if (op == heapCommandPkg::opResize) issueCommand(op, r[5:4], r[7:6], 12'(r[10:8]));
      else issueCommand(op, r[5:4], r[7:6], r[19:8]);
    end

    @(negedge clock);
    cmdValid = 1'b0;
    for (int w = 0; w < 4 && expectedQ.size() != 0; w++) @(posedge clock);
    repeat (2) @(posedge clock);                     // Catch stray responses
    if (expectedQ.size() != 0) begin
      protocolErrors++;
      $display("%0d responses never arrived", expectedQ.size());
    end

    $display("Errors: data %0d, error code %0d, protocol %0d",
             dataErrors, codeErrors, protocolErrors);
    if (dataErrors + codeErrors + protocolErrors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
common/heapGeometryPkg.sv
common/heapCommandPkg.sv
arrayHeap/arrayAllocator.sv
arrayHeap/arraySizeTable.sv
arrayHeap/elementStore.sv
arrayHeap/arrayHeap.sv
sim/tbClockGen.sv
sim/arrayHeapTb.sv

/* Bender.yml */
package:
  name: array_heap

sources:
  - common/heapGeometryPkg.sv
  - common/heapCommandPkg.sv
  - arrayHeap/arrayAllocator.sv
  - arrayHeap/arraySizeTable.sv
  - arrayHeap/elementStore.sv
  - arrayHeap/arrayHeap.sv
  - target: simulation
    files:
      - sim/tbClockGen.sv
      - sim/arrayHeapTb.sv
